// ==== hw/chip_cfg_pkg.sv ====
// Chip-level address configuration for the memory chiplet router.
// All windows are half-open [start, end) on the 40-bit local offset.
// The top address byte is the chip ID and is not part of these bounds.

package chip_cfg_pkg;

  localparam int unsigned AddrWidth  = 48;
  localparam int unsigned LocalWidth = 40;

  typedef logic [7:0] chip_id_t;

  //////////////////////////////
  // Wide crossbar windows
  //////////////////////////////

  localparam logic [LocalWidth-1:0] DefaultMemSize = 40'h00_0010_0000;
  localparam logic [LocalWidth-1:0] MemBase        = 40'h00_8000_0000;

  localparam logic [LocalWidth-1:0] MemAltStart    = 40'h00_FFFF_C000;
  localparam logic [LocalWidth-1:0] MemAltEnd      = 40'h00_FFFF_D000;

  localparam logic [LocalWidth-1:0] NarrowLoStart  = 40'h00_FFFF_B000;
  localparam logic [LocalWidth-1:0] NarrowLoEnd    = 40'h00_FFFF_C000;
  localparam logic [LocalWidth-1:0] NarrowHiStart  = 40'h00_FFFF_D000;
  localparam logic [LocalWidth-1:0] NarrowHiEnd    = 40'h01_0000_0000;

  localparam logic [LocalWidth-1:0] PeriphStart    = 40'h00_0200_0000;
  localparam logic [LocalWidth-1:0] PeriphEnd      = 40'h00_0201_0000;

  // Reserved DRAM port, last offset is left out as in the crossbar rule
  localparam logic [LocalWidth-1:0] DramStart      = 40'h01_0000_0000;
  localparam logic [LocalWidth-1:0] DramEnd        = 40'hFF_FFFF_FFFF;

  //////////////////////////////
  // Peripheral windows
  //////////////////////////////

  localparam logic [LocalWidth-1:0] ClkRstStart    = 40'h00_0200_5000;
  localparam logic [LocalWidth-1:0] ClkRstEnd      = 40'h00_0200_6000;
  localparam logic [LocalWidth-1:0] D2dCtrlStart   = 40'h00_0200_7000;
  localparam logic [LocalWidth-1:0] D2dCtrlEnd     = 40'h00_0200_8000;

  // Half-open window match
  function automatic logic in_window(input logic [LocalWidth-1:0] addr,
                                     input logic [LocalWidth-1:0] start_addr,
                                     input logic [LocalWidth-1:0] end_addr);
    return (addr >= start_addr) && (addr < end_addr);
  endfunction

endpackage

// ==== hw/route_pkg.sv ====
// Request and route types shared by the two decode stages.
// Offsets are the low 40 address bits; the chip ID byte is dropped
// once the wide stage has resolved local versus remote.

package route_pkg;

  import chip_cfg_pkg::*;

  // Wide crossbar master ports, in crossbar port order
  typedef enum logic [1:0] {
    WIDE_D2D    = 2'd0,
    WIDE_MEM    = 2'd1,
    WIDE_NARROW = 2'd2,
    WIDE_DRAM   = 2'd3
  } wide_tgt_e;

  // Final destination after the narrow and peripheral decode
  typedef enum logic [2:0] {
    DEST_D2D        = 3'd0,
    DEST_MEM_WIDE   = 3'd1,
    DEST_MEM_NARROW = 3'd2,
    DEST_CLK_RST    = 3'd3,
    DEST_D2D_CTRL   = 3'd4,
    DEST_DRAM       = 3'd5,
    DEST_PERIPH_ERR = 3'd6
  } dest_e;

  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [AddrWidth-1:0] addr;
  } route_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    wide_tgt_e             tgt;
    logic [LocalWidth-1:0] offset;
  } wide_route_t;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    dest_e                 dest;
    logic [LocalWidth-1:0] offset;
  } route_t;

endpackage

// ==== hw/wide_route_stage.sv ====
// Wide crossbar decode stage, one cycle of latency.
// The chip ID is sampled from chip_id_i on every clock while rst_ni is low
// and held afterwards. Remote and unmapped requests default to the D2D link.

`timescale 1ns/1ps

module wide_route_stage
  import chip_cfg_pkg::*;
  import route_pkg::*;
#(
  parameter logic [LocalWidth-1:0] MemSize = DefaultMemSize
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  chip_id_t    chip_id_i,
  input  route_req_t  req_i,
  output wide_route_t wide_o
);

  localparam logic [LocalWidth-1:0] MemEnd = MemBase + MemSize;

  //////////////////////////////
  // Chip ID capture
  //////////////////////////////

  chip_id_t chip_id_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chip_id_q <= chip_id_i;
    end
  end

  //////////////////////////////
  // Address decode
  //////////////////////////////

  logic [LocalWidth-1:0] offset;
  logic                  is_local;
  wide_tgt_e             tgt_d;

  assign offset   = req_i.addr[LocalWidth-1:0];
  assign is_local = (req_i.addr[AddrWidth-1:LocalWidth] == chip_id_q);

  always_comb begin
    tgt_d = WIDE_D2D;
    if (is_local) begin
      if (in_window(offset, MemBase, MemEnd) ||
          in_window(offset, MemAltStart, MemAltEnd)) begin
        tgt_d = WIDE_MEM;
      end else if (in_window(offset, NarrowLoStart, NarrowLoEnd) ||
                   in_window(offset, NarrowHiStart, NarrowHiEnd) ||
                   in_window(offset, PeriphStart, PeriphEnd)) begin
        tgt_d = WIDE_NARROW;
      end else if (in_window(offset, DramStart, DramEnd)) begin
        tgt_d = WIDE_DRAM;
      end
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  logic                  valid_q;
  logic                  write_q;
  wide_tgt_e             tgt_q;
  logic [LocalWidth-1:0] offset_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
    // Payload only moves with a request
    if (req_i.valid) begin
      write_q  <= req_i.write;
      tgt_q    <= tgt_d;
      offset_q <= offset;
    end
  end

  assign wide_o = '{valid: valid_q, write: write_q, tgt: tgt_q, offset: offset_q};

  // Main memory must not overlap the narrow windows above it
  mem_window_ok_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (MemSize != '0) && (MemEnd <= NarrowLoStart));

endmodule

// ==== hw/narrow_route_stage.sv ====
// Narrow crossbar and peripheral decode stage, one cycle of latency.
// Expects narrow-bound offsets already confined to the narrow or
// peripheral windows by the wide stage. Unmapped peripherals flag an error.

`timescale 1ns/1ps

module narrow_route_stage
  import chip_cfg_pkg::*;
  import route_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  wide_route_t wide_i,
  output route_t      route_o
);

  //////////////////////////////
  // Narrow and peripheral map
  //////////////////////////////

  logic  in_narrow;
  logic  in_periph;
  dest_e dest_d;

  assign in_narrow = in_window(wide_i.offset, NarrowLoStart, NarrowLoEnd) ||
                     in_window(wide_i.offset, NarrowHiStart, NarrowHiEnd);
  assign in_periph = in_window(wide_i.offset, PeriphStart, PeriphEnd);

  always_comb begin
    dest_d = DEST_D2D;
    case (wide_i.tgt)
      WIDE_D2D: begin
        dest_d = DEST_D2D;
      end
      WIDE_MEM: begin
        dest_d = DEST_MEM_WIDE;
      end
      WIDE_DRAM: begin
        dest_d = DEST_DRAM;
      end
      WIDE_NARROW: begin
        if (in_narrow) begin
          dest_d = DEST_MEM_NARROW;
        end else if (in_window(wide_i.offset, ClkRstStart, ClkRstEnd)) begin
          dest_d = DEST_CLK_RST;
        end else if (in_window(wide_i.offset, D2dCtrlStart, D2dCtrlEnd)) begin
          dest_d = DEST_D2D_CTRL;
        end else begin
          // Peripheral window hole, the lite crossbar has no default port
          dest_d = DEST_PERIPH_ERR;
        end
      end
      default: begin
        dest_d = DEST_D2D;
      end
    endcase
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  logic                  valid_q;
  logic                  write_q;
  dest_e                 dest_q;
  logic [LocalWidth-1:0] offset_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= wide_i.valid;
    end
    if (wide_i.valid) begin
      write_q  <= wide_i.write;
      dest_q   <= dest_d;
      offset_q <= wide_i.offset;
    end
  end

  assign route_o = '{valid: valid_q, write: write_q, dest: dest_q, offset: offset_q};

  // Wide stage and narrow stage must agree on the narrow-bound windows
  narrow_in_map_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wide_i.valid && (wide_i.tgt == WIDE_NARROW)) |-> (in_narrow || in_periph));

endmodule

// ==== hw/mem_chip_router.sv ====
// Memory chiplet address router, two register stages from req_i to route_o.
// No handshake: every valid request yields one route two cycles later.
// MemSize sets the main memory window above MemBase.

`timescale 1ns/1ps

module mem_chip_router
  import chip_cfg_pkg::*;
  import route_pkg::*;
#(
  parameter logic [LocalWidth-1:0] MemSize = DefaultMemSize
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  chip_id_t   chip_id_i,
  input  route_req_t req_i,
  output route_t     route_o
);

  wide_route_t wide;

  // Wide crossbar decode with chip ID capture
  wide_route_stage #(
    .MemSize(MemSize)
  ) i_wide_stage (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .chip_id_i(chip_id_i),
    .req_i    (req_i),
    .wide_o   (wide)
  );

  // Narrow crossbar and peripheral decode
  narrow_route_stage i_narrow_stage (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wide_i (wide),
    .route_o(route_o)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset source. Reset is held low for two rising edges.
// The chip ID is 8'h05 during reset and moves to 8'hA0 afterwards,
// so a DUT that keeps sampling it would route local requests as remote.

`timescale 1ns/1ps

module tb_clk_gen
  import chip_cfg_pkg::*;
#(
  parameter int unsigned ClkPeriod = 100
) (
  output logic     clk_o,
  output logic     rst_no,
  output chip_id_t chip_id_o
);

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no    = 1'b0;
    chip_id_o = 8'h05;
    repeat (2) @(posedge clk_o);
    #1;
    rst_no    = 1'b1;
    chip_id_o = 8'hA0;
  end

endmodule

// ==== verif/tb_mem_chip_router.sv ====
// Testbench for the memory chiplet router. Requests go in back to back,
// one per cycle, and each route is checked for destination, write bit,
// offset and a latency of two cycles. Outputs are sampled on the falling edge.

`timescale 1ns/1ps

module tb_mem_chip_router
  import chip_cfg_pkg::*;
  import route_pkg::*;
;

  localparam int unsigned           ClkPeriod  = 100;
  localparam logic [LocalWidth-1:0] MemSize    = DefaultMemSize;
  localparam chip_id_t              LocalChip  = 8'h05;
  localparam int                    NumFixed   = 23;
  localparam int                    NumRand    = 6;
  localparam int                    NumEntries = NumFixed + NumRand;

  typedef struct packed {
    logic                 write;
    logic [AddrWidth-1:0] addr;
    dest_e                dest;
  } stim_t;

  typedef struct packed {
    logic                  write;
    dest_e                 dest;
    logic [LocalWidth-1:0] offset;
    logic [31:0]           cycle;
  } expect_t;

  logic        clk;
  logic        rst_ni;
  chip_id_t    chip_id;
  route_req_t  req;
  route_t      route;
  logic [31:0] cycle_cnt = '0;
  integer      seed;
  int          drv_errors = 0;
  int          mon_errors = 0;
  int          received = 0;
  stim_t       stim_tbl [NumEntries];
  expect_t     exp_q [$];

  tb_clk_gen #(
    .ClkPeriod(ClkPeriod)
  ) i_clk_gen (
    .clk_o    (clk),
    .rst_no   (rst_ni),
    .chip_id_o(chip_id)
  );

  mem_chip_router #(
    .MemSize(MemSize)
  ) i_dut (
    .clk_i    (clk),
    .rst_ni   (rst_ni),
    .chip_id_i(chip_id),
    .req_i    (req),
    .route_o  (route)
  );

  always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

  //////////////////////////////
  // Reference decode
  //////////////////////////////

  function automatic dest_e ref_dest(input logic [AddrWidth-1:0] addr);
    logic [LocalWidth-1:0] off;
    off = addr[LocalWidth-1:0];
    if (addr[AddrWidth-1:LocalWidth] != LocalChip) return DEST_D2D;
    if (off >= MemBase && off < MemBase + MemSize) return DEST_MEM_WIDE;
    if (off >= MemAltStart && off < MemAltEnd) return DEST_MEM_WIDE;
    if (off >= NarrowLoStart && off < NarrowLoEnd) return DEST_MEM_NARROW;
    if (off >= NarrowHiStart && off < NarrowHiEnd) return DEST_MEM_NARROW;
    if (off >= PeriphStart && off < PeriphEnd) begin
      if (off >= ClkRstStart && off < ClkRstEnd) return DEST_CLK_RST;
      if (off >= D2dCtrlStart && off < D2dCtrlEnd) return DEST_D2D_CTRL;
      return DEST_PERIPH_ERR;
    end
    if (off >= DramStart && off < DramEnd) return DEST_DRAM;
    // Unmapped local space falls to the link
    return DEST_D2D;
  endfunction

  function automatic stim_t stim_entry(input logic wr, input logic [AddrWidth-1:0] addr,
                                       input dest_e dest);
    return '{write: wr, addr: addr, dest: dest};
  endfunction

  task automatic load_table();
    logic [31:0]           r;
    int                    pick;
    logic [LocalWidth-1:0] win_lo;
    logic [LocalWidth-1:0] win_hi;
    logic [LocalWidth-1:0] off;
    stim_tbl[0]  = stim_entry(1'b0, 48'h05_0080_000000, DEST_MEM_WIDE);
    stim_tbl[1]  = stim_entry(1'b1, 48'h05_0080_001234, DEST_MEM_WIDE);
    stim_tbl[2]  = stim_entry(1'b0, 48'h05_0080_0FFFFF, DEST_MEM_WIDE);
    stim_tbl[3]  = stim_entry(1'b1, 48'h05_0080_100000, DEST_D2D);
    stim_tbl[4]  = stim_entry(1'b0, 48'h05_00FF_FFC000, DEST_MEM_WIDE);
    stim_tbl[5]  = stim_entry(1'b1, 48'h05_00FF_FFCFFC, DEST_MEM_WIDE);
    stim_tbl[6]  = stim_entry(1'b0, 48'h03_0080_000000, DEST_D2D);
    // The pin chip ID after reset belongs to another chip
    stim_tbl[7]  = stim_entry(1'b1, 48'hA0_0002_005000, DEST_D2D);
    stim_tbl[8]  = stim_entry(1'b0, 48'h05_0000_001000, DEST_D2D);
    stim_tbl[9]  = stim_entry(1'b1, 48'h05_00FF_FFB000, DEST_MEM_NARROW);
    stim_tbl[10] = stim_entry(1'b0, 48'h05_00FF_FFBFFF, DEST_MEM_NARROW);
    stim_tbl[11] = stim_entry(1'b1, 48'h05_00FF_FFD000, DEST_MEM_NARROW);
    stim_tbl[12] = stim_entry(1'b0, 48'h05_00FF_FFFFFF, DEST_MEM_NARROW);
    stim_tbl[13] = stim_entry(1'b1, 48'h05_0100_000000, DEST_DRAM);
    stim_tbl[14] = stim_entry(1'b0, 48'h05_FFFF_FFFFFE, DEST_DRAM);
    stim_tbl[15] = stim_entry(1'b1, 48'h05_0002_005000, DEST_CLK_RST);
    stim_tbl[16] = stim_entry(1'b0, 48'h05_0002_005FFC, DEST_CLK_RST);
    stim_tbl[17] = stim_entry(1'b1, 48'h05_0002_007000, DEST_D2D_CTRL);
    stim_tbl[18] = stim_entry(1'b0, 48'h05_0002_007FF8, DEST_D2D_CTRL);
    stim_tbl[19] = stim_entry(1'b1, 48'h05_0002_006800, DEST_PERIPH_ERR);
    stim_tbl[20] = stim_entry(1'b0, 48'h05_0002_000000, DEST_PERIPH_ERR);
    stim_tbl[21] = stim_entry(1'b1, 48'h05_0002_00FFFF, DEST_PERIPH_ERR);
    stim_tbl[22] = stim_entry(1'b0, 48'h05_0002_010000, DEST_D2D);
    seed = 32'h2d1e3a2a;
    for (int i = NumFixed; i < NumEntries; i++) begin
      r    = $random(seed);
      pick = int'(r % 32'd5);
      case (pick)
        0: begin
          win_lo = MemBase;
          win_hi = MemBase + MemSize;
        end
        1: begin
          win_lo = NarrowHiStart;
          win_hi = NarrowHiEnd;
        end
        2: begin
          win_lo = ClkRstStart;
          win_hi = ClkRstEnd;
        end
        3: begin
          win_lo = D2dCtrlStart;
          win_hi = D2dCtrlEnd;
        end
        default: begin
          win_lo = PeriphStart;
          win_hi = PeriphEnd;
        end
      endcase
      r   = $random(seed);
      off = win_lo + (LocalWidth'(r) % (win_hi - win_lo));
      stim_tbl[i] = stim_entry(r[31], {LocalChip, off}, ref_dest({LocalChip, off}));
    end
  endtask

  //////////////////////////////
  // Stimulus and summary
  //////////////////////////////

  initial begin
    // A request held during reset must not leave the pipeline
    req = '{valid: 1'b1, write: 1'b1, addr: 48'h05_0080_000000};
    load_table();
    @(posedge rst_ni);
    req = '0;
    @(negedge clk);
    assert (route.valid == 1'b0) else begin
      $display("FAIL %0t route_o.valid expected 0 got %0b", $time, route.valid);
      drv_errors++;
    end
    for (int i = 0; i < NumEntries; i++) begin
      @(posedge clk);
      #1;
      req = '{valid: 1'b1, write: stim_tbl[i].write, addr: stim_tbl[i].addr};
      exp_q.push_back('{write: stim_tbl[i].write, dest: stim_tbl[i].dest,
                        offset: stim_tbl[i].addr[LocalWidth-1:0], cycle: cycle_cnt});
    end
    @(posedge clk);
    #1;
    req = '0;
    while (exp_q.size() != 0) @(negedge clk);
    // Idle cycles to catch a stray extra route
    repeat (2) @(negedge clk);
    assert (received == NumEntries) else begin
      $display("Sent %0d requests but saw %0d routes", NumEntries, received);
      drv_errors++;
    end
    $display("Summary: %0d value errors, %0d other errors, %0d of %0d routes seen",
             mon_errors, drv_errors, received, NumEntries);
    if (drv_errors + mon_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  //////////////////////////////
  // Route monitor
  //////////////////////////////

  always @(negedge clk) begin
    expect_t want;
    if (rst_ni && route.valid) begin
      received++;
      assert (exp_q.size() != 0) else begin
        $display("Route at %0t arrived with no request pending", $time);
        drv_errors++;
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        assert (route.dest == want.dest) else begin
          $display("FAIL %0t route_o.dest expected %0d got %0d", $time, want.dest, route.dest);
          mon_errors++;
        end
        assert (route.write == want.write) else begin
          $display("FAIL %0t route_o.write expected %0b got %0b", $time, want.write,
                   route.write);
          mon_errors++;
        end
        assert (route.offset == want.offset) else begin
          $display("FAIL %0t route_o.offset expected %h got %h", $time, want.offset,
                   route.offset);
          mon_errors++;
        end
        assert (cycle_cnt - want.cycle == 32'd2) else begin
          $display("Route at %0t took %0d cycles instead of 2", $time, cycle_cnt - want.cycle);
          drv_errors++;
        end
      end
    end
  end

  // Watchdog sized from the table length plus margin for reset and drain
  initial begin
    #((NumEntries + 20) * ClkPeriod);
    $display("Timeout after %0d cycles with %0d routes still pending",
             NumEntries + 20, exp_q.size());
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== all.f ====
hw/chip_cfg_pkg.sv
hw/route_pkg.sv
hw/wide_route_stage.sv
hw/narrow_route_stage.sv
hw/mem_chip_router.sv
verif/tb_clk_gen.sv
verif/tb_mem_chip_router.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the router testbench with Verilator.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert \
  --top-module tb_mem_chip_router \
  -f all.f \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; then
  exit 0
fi

echo "Pass line not found in simulation output"
exit 1
